// File: rtl/mmu_defines.svh
// size parameters of the Sv32 translation unit
// TLB depth, page offset width and PTE size in bytes
`ifndef MMU_DEFINES_SVH
`define MMU_DEFINES_SVH

// number of TLB entries, kept a power of two so the
// round-robin pointer wraps cleanly
`define MMU_TLB_ENTRIES 4

// byte offset within a 4 KiB page
`define MMU_PAGE_OFFSET_W 12

// each Sv32 PTE is one 32-bit word, so a table index is scaled by this
`define MMU_PTE_BYTES 4

`endif

// File: rtl/sv32_types_pkg.sv
// Sv32 data layouts
// virtual address, PTE permission bits, PTE, TLB entry and satp fields
`default_nettype none

`include "mmu_defines.svh"

package sv32_types_pkg;

  // virtual address split into the two table indices and the page offset
  typedef struct packed {
    logic [9:0]                    vpn1;
    logic [9:0]                    vpn0;
    logic [`MMU_PAGE_OFFSET_W-1:0] offset;
  } sv32_vaddr_t;

  // low ten bits of a PTE, msb first as they sit in memory
  // global is a keyword, hence the longer field name
  typedef struct packed {
    logic [1:0] rsw;
    logic       dirty;
    logic       accessed;
    logic       global_page;
    logic       user;
    logic       executable;
    logic       writable;
    logic       readable;
    logic       valid;
  } pte_perms_t;

  typedef struct packed {
    logic [11:0] ppn1;
    logic [9:0]  ppn0;
    pte_perms_t  perms;
  } pte_sv32_t;

  // a megapage entry only compares the upper half of vpn
  typedef struct packed {
    logic        valid;
    logic        megapage;
    logic [19:0] vpn;
    pte_sv32_t   pte;
  } tlb_entry_t;

  typedef struct packed {
    logic        mode_sv32;
    logic [21:0] root_ppn;
  } satp_t;

endpackage

`default_nettype wire

// File: rtl/priv_types_pkg.sv
// privilege and access encodings, page fault flags and walker states
`default_nettype none

package priv_types_pkg;

  // encodings follow the RISC-V privilege spec
  typedef enum logic [1:0] {
    U_MODE = 2'b00,
    S_MODE = 2'b01,
    M_MODE = 2'b11
  } priv_mode_t;

  typedef enum logic [1:0] {
    LOAD        = 2'd0,
    STORE       = 2'd1,
    INSTRUCTION = 2'd2
  } access_t;

  // at most one flag is set, picked by the access type
  typedef struct packed {
    logic load;
    logic store;
    logic insn;
  } page_fault_t;

  typedef enum logic [2:0] {
    IDLE,
    READ_L1,
    WAIT_L1,
    READ_L0,
    WAIT_L0,
    FINISH
  } walk_state_t;

endpackage

`default_nettype wire

// File: rtl/page_perm_check.sv
// page permission checker for one Sv32 PTE
// shared by the TLB hit path and the page table walker
`timescale 1ns/1ps
`default_nettype none

module page_perm_check (
  input  logic                        check,
  input  logic                        level,
  input  priv_types_pkg::access_t     access,
  input  priv_types_pkg::priv_mode_t  priv,
  input  logic                        sum,
  input  sv32_types_pkg::pte_sv32_t   pte,
  output priv_types_pkg::page_fault_t fault,
  output logic                        leaf_pte
);

  import priv_types_pkg::*;
  import sv32_types_pkg::*;

  pte_perms_t perms;
  logic       bad_pte;
  logic       is_pointer;
  logic       leaf_fault;
  logic       raise;

  assign perms = pte.perms;

  always_comb begin
    // an invalid PTE, or write permission without read, is never usable
    bad_pte = ~perms.valid | (perms.writable & ~perms.readable);

    // with r, w and x all clear the PTE points at the next table
    is_pointer = ~(perms.readable | perms.writable | perms.executable);

    leaf_fault = 1'b0;
    // basic rights for the access type
    // loads also succeed on execute-only pages here
    if (access == INSTRUCTION && !perms.executable) begin
      leaf_fault = 1'b1;
    end
    if (access == STORE && !perms.writable) begin
      leaf_fault = 1'b1;
    end
    if (access == LOAD && !(perms.readable || perms.executable)) begin
      leaf_fault = 1'b1;
    end
    // supervisor may touch user pages only with sum, and never fetch from them
    if (perms.user && priv == S_MODE && (!sum || access == INSTRUCTION)) begin
      leaf_fault = 1'b1;
    end
    if (!perms.user && priv == U_MODE) begin
      leaf_fault = 1'b1;
    end
    // A and D are not updated by hardware, so a missing bit is a fault
    if (!perms.accessed || (access == STORE && !perms.dirty)) begin
      leaf_fault = 1'b1;
    end
    // a megapage must be aligned to 4 MiB
    if (level && pte.ppn0 != '0) begin
      leaf_fault = 1'b1;
    end

    // a pointer is fine at level 1 and a fault at level 0
    raise = check & (bad_pte | (is_pointer & ~level) | (~is_pointer & leaf_fault));
    leaf_pte = check & ~bad_pte & ~is_pointer;

    fault.load  = raise & (access == LOAD);
    fault.store = raise & (access == STORE);
    fault.insn  = raise & (access == INSTRUCTION);
  end

endmodule

`default_nettype wire

// File: rtl/sv32_tlb.sv
// fully associative Sv32 TLB with round-robin replacement
// lookup result is registered and rechecked against the current access
`timescale 1ns/1ps
`default_nettype none

`include "mmu_defines.svh"

module sv32_tlb #(
  parameter int num_entries = `MMU_TLB_ENTRIES
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        lookup,
  input  sv32_types_pkg::sv32_vaddr_t vaddr,
  input  priv_types_pkg::access_t     access,
  input  priv_types_pkg::priv_mode_t  priv,
  input  logic                        sum,
  input  logic                        flush,
  input  logic                        fill_valid,
  input  sv32_types_pkg::tlb_entry_t  fill_entry,
  output logic                        hit_done,
  output logic                        miss,
  output logic [33:0]                 paddr,
  output priv_types_pkg::page_fault_t fault
);

  import priv_types_pkg::*;
  import sv32_types_pkg::*;

  localparam int idx_w = (num_entries > 1) ? $clog2(num_entries) : 1;

  tlb_entry_t             entries [num_entries];
  logic [num_entries-1:0] match;
  tlb_entry_t             hit_entry;
  logic [idx_w-1:0]       victim_q;

  logic        lookup_q;
  logic        hit_q;
  tlb_entry_t  entry_q;
  sv32_vaddr_t vaddr_q;
  access_t     access_q;
  priv_mode_t  priv_q;
  logic        sum_q;

  // compare every slot, megapages ignore vpn0
  always_comb begin
    hit_entry = '0;
    for (int i = 0; i < num_entries; i++) begin
      match[i] = entries[i].valid && entries[i].vpn[19:10] == vaddr.vpn1 &&
                 (entries[i].megapage || entries[i].vpn[9:0] == vaddr.vpn0);
      if (match[i]) begin
        hit_entry = entries[i];
      end
    end
  end

  // flush drops only the valid bits, the payload stays
  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      for (int i = 0; i < num_entries; i++) begin
        entries[i].valid <= 1'b0;
      end
    end else if (fill_valid) begin
      entries[victim_q] <= fill_entry;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      victim_q <= '0;
      lookup_q <= 1'b0;
      hit_q    <= 1'b0;
    end else begin
      lookup_q <= lookup;
      hit_q    <= |match;
      if (fill_valid) begin
        victim_q <= (victim_q == idx_w'(num_entries - 1)) ? '0 : victim_q + 1'b1;
      end
    end
  end

  // request fields held for the check and the address in the next cycle
  always_ff @(posedge clk) begin
    if (lookup) begin
      entry_q  <= hit_entry;
      vaddr_q  <= vaddr;
      access_q <= access;
      priv_q   <= priv;
      sum_q    <= sum;
    end
  end

  assign hit_done = lookup_q & hit_q;
  assign miss     = lookup_q & ~hit_q;

  assign paddr = entry_q.megapage ? {entry_q.pte.ppn1, vaddr_q.vpn0, vaddr_q.offset}
                                  : {entry_q.pte.ppn1, entry_q.pte.ppn0, vaddr_q.offset};

  // cached entries are leaves, so only the fault matters here
  page_perm_check i_perm (
    .check    (hit_done),
    .level    (entry_q.megapage),
    .access   (access_q),
    .priv     (priv_q),
    .sum      (sum_q),
    .pte      (entry_q.pte),
    .fault    (fault),
    .leaf_pte ()
  );

endmodule

`default_nettype wire

// File: rtl/sv32_page_walker.sv
// two-level Sv32 page table walker
// one memory read at a time, result goes to the core and to the TLB
`timescale 1ns/1ps
`default_nettype none

`include "mmu_defines.svh"

module sv32_page_walker (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        start,
  input  sv32_types_pkg::sv32_vaddr_t vaddr,
  input  priv_types_pkg::access_t     access,
  input  priv_types_pkg::priv_mode_t  priv,
  input  logic                        sum,
  input  logic [21:0]                 root_ppn,
  output logic                        mem_req,
  output logic [33:0]                 mem_addr,
  input  logic                        mem_rvalid,
  input  sv32_types_pkg::pte_sv32_t   mem_rdata,
  output logic                        busy,
  output logic                        done,
  output logic [33:0]                 paddr,
  output priv_types_pkg::page_fault_t fault,
  output logic                        fill_valid,
  output sv32_types_pkg::tlb_entry_t  fill_entry
);

  import priv_types_pkg::*;
  import sv32_types_pkg::*;

  walk_state_t state_q;
  walk_state_t state_d;

  logic [21:0] ppn_q;
  pte_sv32_t   pte_q;
  page_fault_t fault_q;
  logic        megapage_q;
  logic [9:0]  vpn_idx;

  logic        chk_en;
  page_fault_t chk_fault;
  logic        chk_leaf;

  // the returned PTE is checked in the same cycle it arrives
  assign chk_en = mem_rvalid & (state_q == WAIT_L1 || state_q == WAIT_L0);

  page_perm_check i_perm (
    .check    (chk_en),
    .level    (state_q == WAIT_L1),
    .access   (access),
    .priv     (priv),
    .sum      (sum),
    .pte      (mem_rdata),
    .fault    (chk_fault),
    .leaf_pte (chk_leaf)
  );

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (start) state_d = READ_L1;
      READ_L1: state_d = WAIT_L1;
      // a fault or a leaf ends the walk, anything else points at level 0
      WAIT_L1: if (mem_rvalid) state_d = (|chk_fault || chk_leaf) ? FINISH : READ_L0;
      READ_L0: state_d = WAIT_L0;
      WAIT_L0: if (mem_rvalid) state_d = FINISH;
      FINISH:  state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // table base and the captured PTE
  always_ff @(posedge clk) begin
    if (state_q == IDLE && start) begin
      ppn_q <= root_ppn;
    end
    if (state_q == WAIT_L1 && mem_rvalid && !(|chk_fault) && !chk_leaf) begin
      ppn_q <= {mem_rdata.ppn1, mem_rdata.ppn0};
    end
    if (chk_en) begin
      pte_q      <= mem_rdata;
      fault_q    <= chk_fault;
      megapage_q <= (state_q == WAIT_L1);
    end
  end

  // PTE address is table base plus the scaled index for this level
  assign vpn_idx  = (state_q == READ_L1) ? vaddr.vpn1 : vaddr.vpn0;
  assign mem_addr = {ppn_q, {`MMU_PAGE_OFFSET_W{1'b0}}} +
                    34'(vpn_idx) * 34'(`MMU_PTE_BYTES);
  assign mem_req  = (state_q == READ_L1) || (state_q == READ_L0);

  assign busy  = (state_q != IDLE);
  assign done  = (state_q == FINISH);
  assign fault = fault_q;

  assign paddr = megapage_q ? {pte_q.ppn1, vaddr.vpn0, vaddr.offset}
                            : {pte_q.ppn1, pte_q.ppn0, vaddr.offset};

  // faulting walks never reach the TLB
  assign fill_valid          = done & ~(|fault_q);
  assign fill_entry.valid    = 1'b1;
  assign fill_entry.megapage = megapage_q;
  assign fill_entry.vpn      = {vaddr.vpn1, vaddr.vpn0};
  assign fill_entry.pte      = pte_q;

endmodule

`default_nettype wire

// File: rtl/sv32_mmu.sv
// Sv32 address translation top level
// bare and M-mode pass-through, TLB lookup and walker on a miss
`timescale 1ns/1ps
`default_nettype none

`include "mmu_defines.svh"

module sv32_mmu (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        req,
  input  sv32_types_pkg::sv32_vaddr_t vaddr,
  input  priv_types_pkg::access_t     access,
  input  priv_types_pkg::priv_mode_t  priv,
  input  logic                        sum,
  input  sv32_types_pkg::satp_t       satp,
  input  logic                        sfence,
  output logic                        mem_req,
  output logic [33:0]                 mem_addr,
  input  logic                        mem_rvalid,
  input  sv32_types_pkg::pte_sv32_t   mem_rdata,
  output logic                        busy,
  output logic                        done,
  output logic [33:0]                 paddr,
  output priv_types_pkg::page_fault_t fault
);

  import priv_types_pkg::*;
  import sv32_types_pkg::*;

  logic        translate;
  logic        bare_done_q;
  logic [33:0] bare_paddr_q;

  sv32_vaddr_t vaddr_q;
  access_t     access_q;
  priv_mode_t  priv_q;
  logic        sum_q;
  logic [21:0] root_q;

  logic        tlb_done;
  logic        tlb_miss;
  logic [33:0] tlb_paddr;
  page_fault_t tlb_fault;

  logic        walk_busy;
  logic        walk_done;
  logic [33:0] walk_paddr;
  page_fault_t walk_fault;
  logic        fill_valid;
  tlb_entry_t  fill_entry;

  // machine mode never translates, even with Sv32 enabled
  assign translate = satp.mode_sv32 & (priv != M_MODE);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bare_done_q <= 1'b0;
    end else begin
      bare_done_q <= req & ~translate;
    end
  end

  // the walker starts a cycle after req, so it works from these copies
  always_ff @(posedge clk) begin
    if (req) begin
      bare_paddr_q <= {2'b00, vaddr};
      vaddr_q      <= vaddr;
      access_q     <= access;
      priv_q       <= priv;
      sum_q        <= sum;
      root_q       <= satp.root_ppn;
    end
  end

  sv32_tlb #(
    .num_entries (`MMU_TLB_ENTRIES)
  ) i_tlb (
    .clk        (clk),
    .rst_n      (rst_n),
    .lookup     (req & translate),
    .vaddr      (vaddr),
    .access     (access),
    .priv       (priv),
    .sum        (sum),
    .flush      (sfence),
    .fill_valid (fill_valid),
    .fill_entry (fill_entry),
    .hit_done   (tlb_done),
    .miss       (tlb_miss),
    .paddr      (tlb_paddr),
    .fault      (tlb_fault)
  );

  sv32_page_walker i_walker (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (tlb_miss),
    .vaddr      (vaddr_q),
    .access     (access_q),
    .priv       (priv_q),
    .sum        (sum_q),
    .root_ppn   (root_q),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr),
    .mem_rvalid (mem_rvalid),
    .mem_rdata  (mem_rdata),
    .busy       (walk_busy),
    .done       (walk_done),
    .paddr      (walk_paddr),
    .fault      (walk_fault),
    .fill_valid (fill_valid),
    .fill_entry (fill_entry)
  );

  // the miss cycle already counts as busy, before the walker leaves IDLE
  assign busy = tlb_miss | walk_busy;
  assign done = bare_done_q | tlb_done | walk_done;

  // only one source fires per request
  always_comb begin
    if (walk_done) begin
      paddr = walk_paddr;
      fault = walk_fault;
    end else if (tlb_done) begin
      paddr = tlb_paddr;
      fault = tlb_fault;
    end else begin
      paddr = bare_paddr_q;
      fault = '0;
    end
  end

endmodule

`default_nettype wire

// File: testbench/sv32_mmu_props.sv
// concurrent assertions on the request, memory and result strobes of the MMU
// bound to sv32_mmu
`timescale 1ns/1ps
`default_nettype none

module sv32_mmu_props (
  input logic clk,
  input logic rst_n,
  input logic req,
  input logic busy,
  input logic mem_req,
  input logic done
);

  // set by the first request after reset
  logic req_seen;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_seen <= 1'b0;
    end else if (req) begin
      req_seen <= 1'b1;
    end
  end

  a_req_idle: assert property (@(posedge clk) disable iff (!rst_n) req |-> !busy)
    else $error("req raised while busy");

  // one outstanding read, so the strobe is a single-cycle pulse
  a_mem_req_pulse: assert property (@(posedge clk) disable iff (!rst_n) mem_req |=> !mem_req)
    else $error("mem_req high on two consecutive cycles");

  a_mem_req_busy: assert property (@(posedge clk) disable iff (!rst_n) mem_req |-> busy)
    else $error("mem_req while not busy");

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else $error("done high on two consecutive cycles");

  a_no_early_mem: assert property (@(posedge clk) disable iff (!rst_n) !req_seen |-> !mem_req)
    else $error("mem_req before the first request");

endmodule

bind sv32_mmu sv32_mmu_props i_props (
  .clk     (clk),
  .rst_n   (rst_n),
  .req     (req),
  .busy    (busy),
  .mem_req (mem_req),
  .done    (done)
);

`default_nettype wire

// File: testbench/sv32_mmu_tb.sv
// testbench for the Sv32 MMU
// clock, reset, PTE memory with LFSR delays, page tables and directed tests
`timescale 1ns/1ps
`default_nettype none

`include "mmu_defines.svh"

module sv32_mmu_tb;

  import priv_types_pkg::*;
  import sv32_types_pkg::*;

  // 6 tests of at most 40 requests, each well under 12 cycles
  localparam int          timeout_cycles = 6 * 40 * 12;
  localparam logic [21:0] root_table     = 22'h00100;
  localparam logic [21:0] table_a        = 22'h00201;

  // permission masks in PTE bit order
  localparam logic [9:0] perm_v    = 10'h001;
  localparam logic [9:0] perm_r    = 10'h002;
  localparam logic [9:0] perm_w    = 10'h004;
  localparam logic [9:0] perm_x    = 10'h008;
  localparam logic [9:0] perm_u    = 10'h010;
  localparam logic [9:0] perm_a    = 10'h040;
  localparam logic [9:0] perm_d    = 10'h080;
  localparam logic [9:0] leaf_rw   = perm_v | perm_r | perm_w | perm_a | perm_d;
  localparam logic [9:0] leaf_rwx  = leaf_rw | perm_x;

  logic        clk;
  logic        rst_n;
  logic        req;
  sv32_vaddr_t vaddr;
  access_t     access;
  priv_mode_t  priv;
  logic        sum;
  satp_t       satp;
  logic        sfence;
  logic        mem_req;
  logic [33:0] mem_addr;
  logic        mem_rvalid;
  pte_sv32_t   mem_rdata;
  logic        busy;
  logic        done;
  logic [33:0] paddr;
  page_fault_t fault;

  // PTE memory keyed by physical address, unwritten words read as invalid PTEs
  pte_sv32_t   page_mem [logic [33:0]];
  logic [31:0] lfsr_q;
  logic        mem_pending;
  logic [2:0]  mem_wait;
  logic [33:0] mem_pend_addr;
  int          mem_reads;
  int          cycle_count;

  sv32_mmu i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .vaddr      (vaddr),
    .access     (access),
    .priv       (priv),
    .sum        (sum),
    .satp       (satp),
    .sfence     (sfence),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr),
    .mem_rvalid (mem_rvalid),
    .mem_rdata  (mem_rdata),
    .busy       (busy),
    .done       (done),
    .paddr      (paddr),
    .fault      (fault)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // galois form of x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (out) begin
      lfsr_q = lfsr_q ^ 32'h8020_0003;
    end
    return out;
  endfunction

  function automatic pte_sv32_t read_pte(input logic [33:0] addr);
    if (page_mem.exists(addr)) begin
      return page_mem[addr];
    end
    return '0;
  endfunction

  // one read in flight, answered 1 to 4 cycles after mem_req
  always @(posedge clk) begin : mem_model
    logic [2:0] delay;
    mem_rvalid <= 1'b0;
    if (mem_req) begin
      delay = 3'd1;
      if (lfsr_bit()) begin
        delay = delay + 3'd1;
      end
      if (lfsr_bit()) begin
        delay = delay + 3'd2;
      end
      mem_pending = 1'b1;
      mem_wait = delay;
      mem_pend_addr = mem_addr;
      mem_reads++;
    end
    if (mem_pending) begin
      mem_wait = mem_wait - 3'd1;
      if (mem_wait == 3'd0) begin
        mem_rvalid <= 1'b1;
        mem_rdata <= read_pte(mem_pend_addr);
        mem_pending = 1'b0;
      end
    end
  end

  task automatic stop_on_error();
    $display("Errors found");
    $fatal(1, "stopping at the first error");
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > timeout_cycles) begin
      $display("timeout: tests still running after %0d cycles", timeout_cycles);
      stop_on_error();
    end
  end

  task automatic check_hex(input string name, input logic [33:0] got, input logic [33:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      $display("error: %s", what);
      stop_on_error();
    end
  endtask

  function automatic sv32_vaddr_t make_vaddr(input logic [9:0] v1, input logic [9:0] v0,
                                             input logic [11:0] off);
    sv32_vaddr_t va;
    va.vpn1 = v1;
    va.vpn0 = v0;
    va.offset = off;
    return va;
  endfunction

  function automatic pte_sv32_t pte_of(input logic [21:0] ppn, input logic [9:0] perms);
    pte_sv32_t p;
    p.ppn1 = ppn[21:10];
    p.ppn0 = ppn[9:0];
    p.perms = pte_perms_t'(perms);
    return p;
  endfunction

  // a fault sets only the flag of its own access type
  function automatic page_fault_t fault_for(input access_t acc);
    page_fault_t f;
    f.load = (acc == LOAD);
    f.store = (acc == STORE);
    f.insn = (acc == INSTRUCTION);
    return f;
  endfunction

  // table base is ppn times page size, each index steps by one PTE
  task automatic set_pte(input logic [21:0] table_ppn, input logic [9:0] idx,
                         input pte_sv32_t pte);
    page_mem[{table_ppn, {`MMU_PAGE_OFFSET_W{1'b0}}} + 34'(idx) * `MMU_PTE_BYTES] = pte;
  endtask

  task automatic build_page_tables();
    set_pte(root_table, 10'd1, pte_of(table_a, perm_v));
    set_pte(root_table, 10'd2, pte_of({12'h0ab, 10'h000}, leaf_rwx));
    // megapage with nonzero ppn0 is misaligned
    set_pte(root_table, 10'd3, pte_of({12'h0ac, 10'h001}, leaf_rwx));
    set_pte(table_a, 10'd0, pte_of(22'h12345, leaf_rw));
    set_pte(table_a, 10'd1, pte_of(22'h12346, perm_v | perm_r | perm_a | perm_d));
    set_pte(table_a, 10'd3, pte_of(22'h12347, leaf_rw | perm_u));
    set_pte(table_a, 10'd5, '0);
    set_pte(table_a, 10'd6, pte_of(22'h12348, perm_v | perm_w | perm_a | perm_d));
    set_pte(table_a, 10'd7, pte_of(22'h12349, perm_v));
    set_pte(table_a, 10'd8, pte_of(22'h1234a, perm_v | perm_r | perm_w | perm_d));
    set_pte(table_a, 10'd9, pte_of(22'h1234b, perm_v | perm_r | perm_w | perm_a));
    for (int i = 0; i <= `MMU_TLB_ENTRIES; i++) begin
      set_pte(table_a, 10'(16 + i), pte_of(22'h30000 + 22'(i), leaf_rw));
    end
  endtask

  // one request, then wait for done and count the memory reads it caused
  // busy is sampled in every cycle from the one after req up to done
  task automatic translate(input sv32_vaddr_t va, input access_t acc, input priv_mode_t pm,
                           input logic s, input logic sv32_on, output logic [33:0] pa,
                           output page_fault_t pf, output int lat, output int reads,
                           output int busy_cycles);
    int reads_before;
    @(negedge clk);
    while (busy) @(negedge clk);
    reads_before = mem_reads;
    @(posedge clk);
    req <= 1'b1;
    vaddr <= va;
    access <= acc;
    priv <= pm;
    sum <= s;
    satp <= '{mode_sv32: sv32_on, root_ppn: root_table};
    @(posedge clk);
    req <= 1'b0;
    lat = 0;
    busy_cycles = 0;
    do begin
      @(negedge clk);
      lat++;
      if (busy) begin
        busy_cycles++;
      end
    end while (!done);
    pa = paddr;
    pf = fault;
    reads = mem_reads - reads_before;
  endtask

  task automatic check_xlate(input sv32_vaddr_t va, input access_t acc, input priv_mode_t pm,
                             input logic s, input logic sv32_on, input logic expect_fault,
                             input logic [33:0] exp_pa, input int exp_reads,
                             input logic single_cycle);
    logic [33:0] pa;
    page_fault_t pf;
    int          lat;
    int          reads;
    int          busy_cycles;
    translate(va, acc, pm, s, sv32_on, pa, pf, lat, reads, busy_cycles);
    if (expect_fault) begin
      check_hex("fault", {31'b0, pf}, {31'b0, fault_for(acc)});
    end else begin
      check_hex("fault", {31'b0, pf}, 34'h0);
      check_hex("paddr", pa, exp_pa);
    end
    check_hex("mem_req count", 34'(reads), 34'(exp_reads));
    // a walk holds busy from the miss cycle through done, a hit never raises it
    check_hex("busy cycles", 34'(busy_cycles), (exp_reads > 0) ? 34'(lat) : 34'h0);
    if (single_cycle) begin
      check_true(lat == 1, "done did not come exactly one cycle after req");
    end
  endtask

  task automatic flush_tlb();
    @(negedge clk);
    while (busy) @(negedge clk);
    @(posedge clk);
    sfence <= 1'b1;
    @(posedge clk);
    sfence <= 1'b0;
  endtask

  task automatic test_bare_mode();
    $display("test: bare and M-mode pass-through");
    check_xlate(32'hdead_beef, LOAD, S_MODE, 1'b0, 1'b0, 1'b0, 34'h0_dead_beef, 0, 1'b1);
    check_xlate(32'h8000_0ffc, INSTRUCTION, U_MODE, 1'b0, 1'b0, 1'b0, 34'h0_8000_0ffc, 0, 1'b1);
    // sv32 on, but machine mode bypasses translation
    check_xlate(32'h1234_5678, STORE, M_MODE, 1'b0, 1'b1, 1'b0, 34'h0_1234_5678, 0, 1'b1);
  endtask

  task automatic test_tlb_hit_flush();
    $display("test: 4 KiB walk, TLB hit and sfence");
    flush_tlb();
    check_xlate(make_vaddr(10'd1, 10'd0, 12'habc), LOAD, S_MODE, 1'b0, 1'b1, 1'b0,
                {22'h12345, 12'habc}, 2, 1'b0);
    check_xlate(make_vaddr(10'd1, 10'd0, 12'habc), LOAD, S_MODE, 1'b0, 1'b1, 1'b0,
                {22'h12345, 12'habc}, 0, 1'b1);
    check_xlate(make_vaddr(10'd1, 10'd0, 12'h010), STORE, S_MODE, 1'b0, 1'b1, 1'b0,
                {22'h12345, 12'h010}, 0, 1'b1);
    flush_tlb();
    check_xlate(make_vaddr(10'd1, 10'd0, 12'habc), LOAD, S_MODE, 1'b0, 1'b1, 1'b0,
                {22'h12345, 12'habc}, 2, 1'b0);
  endtask

  task automatic test_megapage();
    $display("test: megapage");
    flush_tlb();
    // vpn0 of the request passes straight into the physical address
    check_xlate(make_vaddr(10'd2, 10'h155, 12'h123), INSTRUCTION, S_MODE, 1'b0, 1'b1, 1'b0,
                {12'h0ab, 10'h155, 12'h123}, 1, 1'b0);
    check_xlate(make_vaddr(10'd2, 10'h2aa, 12'h456), LOAD, S_MODE, 1'b0, 1'b1, 1'b0,
                {12'h0ab, 10'h2aa, 12'h456}, 0, 1'b1);
    check_xlate(make_vaddr(10'd3, 10'h001, 12'h000), LOAD, S_MODE, 1'b0, 1'b1, 1'b1,
                34'h0, 1, 1'b0);
  endtask

  task automatic test_permissions();
    $display("test: permission rules");
    flush_tlb();
    check_xlate(make_vaddr(10'd1, 10'd1, 12'h004), STORE, S_MODE, 1'b0, 1'b1, 1'b1,
                34'h0, 2, 1'b0);
    check_xlate(make_vaddr(10'd1, 10'd0, 12'h008), INSTRUCTION, S_MODE, 1'b0, 1'b1, 1'b1,
                34'h0, 2, 1'b0);
    check_xlate(make_vaddr(10'd1, 10'd3, 12'h00c), LOAD, S_MODE, 1'b0, 1'b1, 1'b1,
                34'h0, 2, 1'b0);
    check_xlate(make_vaddr(10'd1, 10'd3, 12'h00c), LOAD, S_MODE, 1'b1, 1'b1, 1'b0,
                {22'h12347, 12'h00c}, 2, 1'b0);
    // the cached user page is rechecked against each new privilege
    check_xlate(make_vaddr(10'd1, 10'd3, 12'h010), LOAD, U_MODE, 1'b0, 1'b1, 1'b0,
                {22'h12347, 12'h010}, 0, 1'b1);
    check_xlate(make_vaddr(10'd1, 10'd3, 12'h014), LOAD, S_MODE, 1'b0, 1'b1, 1'b1,
                34'h0, 0, 1'b1);
    check_xlate(make_vaddr(10'd1, 10'd0, 12'h018), LOAD, U_MODE, 1'b0, 1'b1, 1'b1,
                34'h0, 2, 1'b0);
  endtask

  // a fault leaves the TLB untouched, so the repeat walks again
  task automatic expect_uncached_fault(input sv32_vaddr_t va, input access_t acc,
                                       input int exp_reads);
    check_xlate(va, acc, S_MODE, 1'b0, 1'b1, 1'b1, 34'h0, exp_reads, 1'b0);
    check_xlate(va, acc, S_MODE, 1'b0, 1'b1, 1'b1, 34'h0, exp_reads, 1'b0);
  endtask

  task automatic test_faults_uncached();
    $display("test: PTE faults are not cached");
    flush_tlb();
    expect_uncached_fault(make_vaddr(10'd5, 10'd0, 12'h000), LOAD, 1);
    expect_uncached_fault(make_vaddr(10'd1, 10'd5, 12'h020), LOAD, 2);
    expect_uncached_fault(make_vaddr(10'd1, 10'd6, 12'h024), LOAD, 2);
    expect_uncached_fault(make_vaddr(10'd1, 10'd7, 12'h028), INSTRUCTION, 2);
    expect_uncached_fault(make_vaddr(10'd1, 10'd8, 12'h02c), LOAD, 2);
    expect_uncached_fault(make_vaddr(10'd1, 10'd9, 12'h030), STORE, 2);
  endtask

  task automatic test_replacement();
    $display("test: round-robin replacement");
    flush_tlb();
    for (int i = 0; i <= `MMU_TLB_ENTRIES; i++) begin
      check_xlate(make_vaddr(10'd1, 10'(16 + i), 12'h040), LOAD, S_MODE, 1'b0, 1'b1, 1'b0,
                  {22'h30000 + 22'(i), 12'h040}, 2, 1'b0);
    end
    // the extra fill wrapped around onto the slot of the first page
    check_xlate(make_vaddr(10'd1, 10'(16 + `MMU_TLB_ENTRIES), 12'h044), LOAD, S_MODE, 1'b0,
                1'b1, 1'b0, {22'h30000 + 22'(`MMU_TLB_ENTRIES), 12'h044}, 0, 1'b1);
    // the second page still sits in its own slot
    check_xlate(make_vaddr(10'd1, 10'd17, 12'h04c), LOAD, S_MODE, 1'b0, 1'b1, 1'b0,
                {22'h30001, 12'h04c}, 0, 1'b1);
    check_xlate(make_vaddr(10'd1, 10'd16, 12'h048), LOAD, S_MODE, 1'b0, 1'b1, 1'b0,
                {22'h30000, 12'h048}, 2, 1'b0);
  endtask

  initial begin
    rst_n = 1'b0;
    req = 1'b0;
    vaddr = '0;
    access = LOAD;
    priv = S_MODE;
    sum = 1'b0;
    satp = '0;
    sfence = 1'b0;
    mem_rvalid = 1'b0;
    mem_rdata = '0;
    lfsr_q = 32'h38c3_9f5e;
    mem_pending = 1'b0;
    mem_wait = '0;
    mem_pend_addr = '0;
    mem_reads = 0;
    cycle_count = 0;
    build_page_tables();
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    test_bare_mode();
    test_tlb_hit_flush();
    test_megapage();
    test_permissions();
    test_faults_uncached();
    test_replacement();
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+rtl
rtl/sv32_types_pkg.sv
rtl/priv_types_pkg.sv
rtl/page_perm_check.sv
rtl/sv32_tlb.sv
rtl/sv32_page_walker.sv
rtl/sv32_mmu.sv
testbench/sv32_mmu_props.sv
testbench/sv32_mmu_tb.sv

// File: Makefile
# Verilator build and run for the Sv32 MMU testbench
# any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= sv32_mmu_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= No errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	rm -f $(LOG)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
